// File: files.f
logic/adc_cfg_pkg.sv
logic/adc_frame_pkg.sv
logic/scan_sequencer.sv
logic/conversion_ctrl.sv
logic/packet_builder.sv
logic/frame_writer.sv
logic/adc_capture_top.sv
verification/tb_adc_capture.sv

// File: Bender.yml
package:
  name: adc_capture

sources:
  # Packages first, the RTL blocks import them
  - logic/adc_cfg_pkg.sv
  - logic/adc_frame_pkg.sv
  - logic/scan_sequencer.sv
  - logic/conversion_ctrl.sv
  - logic/packet_builder.sv
  - logic/frame_writer.sv
  - logic/adc_capture_top.sv
  - target: simulation
    files:
      - verification/tb_adc_capture.sv

// File: verification/tb_adc_capture.sv
`timescale 1ns/10ps

module tb_adc_capture;

    import adc_cfg_pkg::*;
    import adc_frame_pkg::*;

    localparam int FAST_DELAY   = 2;
    localparam int SLOW_DELAY   = 20;
    localparam int SAMPLES_ALL  = 10 + 7 + NUM_VMM * 5 + 760 + 4;
    localparam int CYC_PER_SMP  = 16;   // Worst ADC latency plus handshakes
    localparam int RUN_OVERHEAD = 100;  // Request, chip changes, release
    localparam int TIMEOUT_CYC  = 2 * (SAMPLES_ALL * (CYC_PER_SMP + FAST_DELAY)
                                       + 4 * (SLOW_DELAY + 1) + 5 * RUN_OVERHEAD);

    logic                    clk200 = 1'b0;
    logic                    rst;
    logic                    data_in_rdy;
    logic [VMM_ID_W-1:0]     vmm_id;
    logic [SAMPLE_CNT_W-1:0] sample_size;
    logic [DELAY_W-1:0]      delay_in;
    logic                    udp_done;
    conv_rsp_t               adc_rsp;
    conv_req_t               adc_req;
    logic [FIFO_W-1:0]       fifo_data;
    logic                    fifo_wr;
    logic [PKT_LEN_W-1:0]    packet_len;
    logic                    end_of_data;
    logic                    busy;

    // ADC model
    integer              seed = 5;
    logic                adc_active;
    int                  lat_left;
    logic [CHAN_W-1:0]   adc_chan;
    logic [8:0]          res_cnt;   // Running part of each result
    logic [SAMPLE_W-1:0] res_val;

    // Observed traffic of the current run
    logic [SAMPLE_W-1:0]  result_q[$];
    logic [CHAN_W-1:0]    chan_q[$];
    int                   start_q[$];    // Cycle of each ADC start
    logic [FIFO_W-1:0]    word_q[$];
    logic [PKT_LEN_W-1:0] len_q[$];      // packet_len beside each upper word
    logic [PKT_LEN_W-1:0] eod_len_q[$];
    int                   eod_words_q[$];
    int                   eod_run = 0;
    int                   cycle = 0;

    adc_capture_top i_dut
    (
        .clk200      (clk200),
        .rst         (rst),
        .data_in_rdy (data_in_rdy),
        .vmm_id      (vmm_id),
        .sample_size (sample_size),
        .delay_in    (delay_in),
        .udp_done    (udp_done),
        .adc_rsp     (adc_rsp),
        .adc_req     (adc_req),
        .fifo_data   (fifo_data),
        .fifo_wr     (fifo_wr),
        .packet_len  (packet_len),
        .end_of_data (end_of_data),
        .busy        (busy)
    );

    always #10 clk200 = ~clk200;

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    always @(posedge clk200)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYC)
        begin
            $display("Timeout: the DUT did not finish the tests within %0d cycles",
                     TIMEOUT_CYC);
            abort_run();
        end
    end

    //////////////////////////////
    // ADC and FIFO side models
    //////////////////////////////

    always @(posedge clk200)
    begin
        adc_rsp.done <= 1'b0;
        if (rst)
        begin
            adc_active <= 1'b0;
            res_cnt    <= '0;
        end
        else if (adc_req.start)
        begin
            adc_active <= 1'b1;
            adc_chan   <= adc_req.chan;
            lat_left   <= 3 + {$random(seed)} % 8;  // 3 to 10 cycles
            chan_q.push_back(adc_req.chan);
            start_q.push_back(cycle);
        end
        else if (adc_active)
        begin
            if (lat_left <= 1)
            begin
                res_val = {adc_chan[2:0], res_cnt};
                adc_rsp.done <= 1'b1;
                adc_rsp.data <= res_val;
                res_cnt      <= res_cnt + 1'b1;
                adc_active   <= 1'b0;
                result_q.push_back(res_val);
            end
            else
                lat_left <= lat_left - 1;
        end
    end

    always @(posedge clk200)
    begin
        if (!rst)
        begin
            if (fifo_wr)
            begin
                if (word_q.size() % 2 == 0)
                    len_q.push_back(packet_len);
                word_q.push_back(fifo_data);
            end
            if (end_of_data)
            begin
                if (eod_run == 0)
                begin
                    eod_len_q.push_back(packet_len);
                    eod_words_q.push_back(word_q.size());
                end
                eod_run++;
            end
            else if (eod_run != 0)
            begin
                compare_value("end_of_data cycles", eod_run, 2);  // Held for the slow side
                eod_run = 0;
            end
        end
    end

    //////////////////////////////
    // Run helpers
    //////////////////////////////

    function automatic int frames_per_chip(input int size);
        int pkts;
        pkts = (size + SLOTS_PER_PKT - 1) / SLOTS_PER_PKT;
        return (pkts + MAX_PACKETS - 1) / MAX_PACKETS;
    endfunction

    task automatic request_run(input int id, input int size, input int delay,
                               input bit hold_rdy);
        result_q.delete();
        chan_q.delete();
        start_q.delete();
        word_q.delete();
        len_q.delete();
        eod_len_q.delete();
        eod_words_q.delete();
        @(posedge clk200);
        vmm_id      <= VMM_ID_W'(id);
        sample_size <= SAMPLE_CNT_W'(size);
        delay_in    <= DELAY_W'(delay);
        data_in_rdy <= 1'b1;
        @(posedge clk200);
        compare_value("busy", busy, 0);
        if (!hold_rdy)
            data_in_rdy <= 1'b0;
        @(posedge clk200);
        compare_value("busy", busy, 1);  // One cycle after the request
    endtask

    task automatic release_run(input bit hold_rdy);
        repeat (4)
        begin
            @(posedge clk200);
            compare_value("busy", busy, 1);  // udp_done still low
        end
        udp_done <= 1'b1;
        if (hold_rdy)
        begin
            repeat (4)
            begin
                @(posedge clk200);
                compare_value("busy", busy, 1);
            end
            data_in_rdy <= 1'b0;
        end
        @(posedge clk200);
        compare_value("busy", busy, 1);
        @(posedge clk200);
        compare_value("busy", busy, 0);
        udp_done <= 1'b0;
    endtask

    // Rebuilds every packet from the ADC results in chip order
    task automatic verify_run(input int first_chip, input int n_chips, input int size);
        logic [PKT_W-1:0]    exp_pkt;
        logic [SAMPLE_W-1:0] res;
        int                  chip;
        int                  slot;
        int                  pkts;
        int                  in_frame;
        int                  pkts_per_chip;
        pkts_per_chip = (size + SLOTS_PER_PKT - 1) / SLOTS_PER_PKT;
        compare_value("adc conversions", result_q.size(), n_chips * size);
        compare_value("adc starts", chan_q.size(), n_chips * size);
        compare_value("fifo_wr words", word_q.size(), 2 * n_chips * pkts_per_chip);
        compare_value("packet_len samples", len_q.size(), n_chips * pkts_per_chip);
        compare_value("end_of_data pulses", eod_len_q.size(), n_chips * frames_per_chip(size));
        pkts     = 0;
        in_frame = 0;
        for (int c = 0; c < n_chips; c++)
        begin
            chip    = first_chip + c;
            slot    = 0;
            exp_pkt = '0;
            for (int s = 0; s < size; s++)
            begin
                res = result_q.pop_front();
                compare_value("adc_req.chan", chan_q.pop_front(), chip);
                exp_pkt[PKT_W-1 -: HDR_W]          = HDR_W'(chip);
                exp_pkt[slot*SAMPLE_W +: SAMPLE_W] = res;
                slot++;
                if (slot == SLOTS_PER_PKT || s == size - 1)
                begin
                    pkts++;
                    in_frame++;
                    compare_value("packet_len", len_q.pop_front(), in_frame);
                    compare_value("fifo_data upper", word_q.pop_front(), exp_pkt[PKT_W-1:FIFO_W]);
                    compare_value("fifo_data lower", word_q.pop_front(), exp_pkt[FIFO_W-1:0]);
                    if (in_frame == MAX_PACKETS || s == size - 1)
                    begin
                        compare_value("packet_len at end_of_data",
                                      eod_len_q.pop_front(), in_frame);
                        compare_value("words at end_of_data", eod_words_q.pop_front(), 2 * pkts);
                        in_frame = 0;
                    end
                    slot    = 0;
                    exp_pkt = '0;  // Unused slots read zero
                end
            end
        end
    endtask

    task automatic run_checked(input int id, input int size, input int delay,
                               input bit hold_rdy, input int first_chip, input int n_chips);
        int frames;
        frames = n_chips * frames_per_chip(size);
        request_run(id, size, delay, hold_rdy);
        while (eod_len_q.size() < frames)
            @(posedge clk200);
        release_run(hold_rdy);
        verify_run(first_chip, n_chips, size);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic single_chip_whole_packets();
        run_checked(3, 10, FAST_DELAY, 1'b0, 2, 1);  // Two packets and a bare last
    endtask

    task automatic partial_packet();
        run_checked(8, 7, FAST_DELAY, 1'b0, 7, 1);
    endtask

    task automatic all_chips_scan();
        run_checked(0, 5, FAST_DELAY, 1'b0, 0, NUM_VMM);
    endtask

    task automatic frame_limit();
        run_checked(1, 760, FAST_DELAY, 1'b0, 0, 1);  // 152 packets split at 150
    endtask

    task automatic delay_and_release();
        run_checked(6, 4, SLOW_DELAY, 1'b1, 5, 1);
        for (int i = 1; i < start_q.size(); i++)
            compare_value("adc_req.start spacing ok",
                          (start_q[i] - start_q[i-1]) >= SLOW_DELAY, 1);
        repeat (20)
        begin
            @(posedge clk200);
            compare_value("fifo_wr", fifo_wr, 0);
            compare_value("adc_req.start", adc_req.start, 0);
            compare_value("busy", busy, 0);
        end
    endtask

    initial
    begin
        rst         = 1'b1;
        data_in_rdy = 1'b0;
        vmm_id      = '0;
        sample_size = '0;
        delay_in    = '0;
        udp_done    = 1'b0;
        adc_rsp     = '0;
        repeat (3) @(posedge clk200);
        rst <= 1'b0;
        repeat (2) @(posedge clk200);
        single_chip_whole_packets();
        partial_packet();
        all_chips_scan();
        frame_limit();
        delay_and_release();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: logic/adc_capture_top.sv
`timescale 1ns/10ps

module adc_capture_top
(
    input  logic                                 clk200,
    input  logic                                 rst,
    input  logic                                 data_in_rdy,
    input  logic [adc_cfg_pkg::VMM_ID_W-1:0]     vmm_id,
    input  logic [adc_cfg_pkg::SAMPLE_CNT_W-1:0] sample_size,
    input  logic [adc_cfg_pkg::DELAY_W-1:0]      delay_in,
    input  logic                                 udp_done,
    input  adc_frame_pkg::conv_rsp_t             adc_rsp,
    output adc_frame_pkg::conv_req_t             adc_req,
    output logic [adc_cfg_pkg::FIFO_W-1:0]       fifo_data,
    output logic                                 fifo_wr,
    output logic [adc_cfg_pkg::PKT_LEN_W-1:0]    packet_len,
    output logic                                 end_of_data,
    output logic                                 busy
);

    import adc_cfg_pkg::*;

    logic                   sample_req;
    logic                   sample_done;
    logic                   flush_req;
    logic                   frame_done;
    logic [VMM_IDX_W-1:0]   vmm_sel;
    adc_frame_pkg::sample_t sample;
    adc_frame_pkg::pkt_t    pkt;

    //////////////////////////////
    // Run control and ADC side
    //////////////////////////////

    scan_sequencer i_scan_sequencer
    (
        .clk200      (clk200),
        .rst         (rst),
        .data_in_rdy (data_in_rdy),
        .vmm_id      (vmm_id),
        .sample_size (sample_size),
        .delay_in    (delay_in),
        .udp_done    (udp_done),
        .sample_done (sample_done),
        .frame_done  (frame_done),
        .sample_req  (sample_req),
        .flush_req   (flush_req),
        .vmm_sel     (vmm_sel),
        .busy        (busy)
    );

    conversion_ctrl i_conversion_ctrl
    (
        .clk200      (clk200),
        .rst         (rst),
        .sample_req  (sample_req),
        .vmm_sel     (vmm_sel),
        .adc_rsp     (adc_rsp),
        .adc_req     (adc_req),
        .sample      (sample),
        .sample_done (sample_done)
    );

    //////////////////////////////
    // Packet path to the data FIFO
    //////////////////////////////

    packet_builder i_packet_builder
    (
        .clk200    (clk200),
        .rst       (rst),
        .sample    (sample),
        .flush_req (flush_req),
        .pkt       (pkt)
    );

    frame_writer i_frame_writer
    (
        .clk200      (clk200),
        .rst         (rst),
        .pkt         (pkt),
        .fifo_data   (fifo_data),
        .fifo_wr     (fifo_wr),
        .packet_len  (packet_len),
        .end_of_data (end_of_data),
        .frame_done  (frame_done)
    );

endmodule

// File: logic/frame_writer.sv
`timescale 1ns/10ps

module frame_writer
(
    input  logic                              clk200,
    input  logic                              rst,
    input  adc_frame_pkg::pkt_t               pkt,
    output logic [adc_cfg_pkg::FIFO_W-1:0]    fifo_data,
    output logic                              fifo_wr,
    output logic [adc_cfg_pkg::PKT_LEN_W-1:0] packet_len,
    output logic                              end_of_data,
    output logic                              frame_done
);

    import adc_cfg_pkg::*;
    import adc_frame_pkg::*;

    adc_packet_u          word_q;
    logic [2:0]           ph;        // 0 idle, 1..4 cycles after accept
    logic                 has_data;  // Clear for a bare last
    logic                 last_q;
    logic                 eod_q;     // End of data due in cycle 3
    logic [PKT_CNT_W-1:0] pkt_cnt;   // Packets in the current frame
    logic [PKT_CNT_W-1:0] cnt_inc;

    assign cnt_inc = pkt_cnt + 1'b1;

    // Upper word in cycle 1, lower word in cycle 2
    assign fifo_data = (ph == 3'd1) ? word_q.words.upper : word_q.words.lower;

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            ph          <= 3'd0;
            fifo_wr     <= 1'b0;
            end_of_data <= 1'b0;
            frame_done  <= 1'b0;
            pkt_cnt     <= '0;
            packet_len  <= '0;
        end
        else
        begin
            case (ph)
                3'd0:
                begin
                    if (pkt.valid || pkt.last)
                    begin
                        ph       <= 3'd1;
                        word_q   <= pkt.packet;
                        has_data <= pkt.valid;
                        last_q   <= pkt.last;
                        eod_q    <= pkt.last ||
                                    (pkt.valid && cnt_inc == PKT_CNT_W'(MAX_PACKETS));
                        fifo_wr  <= pkt.valid;
                        if (pkt.valid)
                        begin
                            pkt_cnt    <= cnt_inc;
                            packet_len <= PKT_LEN_W'(cnt_inc);
                        end
                    end
                end

                3'd1:
                begin
                    fifo_wr <= has_data;
                    ph      <= 3'd2;
                    // Empty flush right behind a full packet closes its frame
                    if (pkt.last)
                    begin
                        last_q <= 1'b1;
                        eod_q  <= 1'b1;
                    end
                end

                3'd2:
                begin
                    fifo_wr     <= 1'b0;
                    end_of_data <= eod_q;
                    frame_done  <= last_q;
                    if (eod_q)
                        pkt_cnt <= '0;  // New frame
                    ph <= 3'd3;
                end

                3'd3: // End of data held a second cycle for the slower clock
                begin
                    frame_done <= 1'b0;
                    ph         <= 3'd4;
                end

                default:
                begin
                    end_of_data <= 1'b0;
                    ph          <= 3'd0;
                end
            endcase
        end
    end

    // Sample spacing keeps packets from overlapping a write
    a_no_overlap: assert property (@(posedge clk200) disable iff (rst)
        pkt.valid |-> (ph == 3'd0));

endmodule

// File: logic/packet_builder.sv
`timescale 1ns/10ps

module packet_builder
(
    input  logic                   clk200,
    input  logic                   rst,
    input  adc_frame_pkg::sample_t sample,
    input  logic                   flush_req,
    output adc_frame_pkg::pkt_t    pkt
);

    import adc_cfg_pkg::*;
    import adc_frame_pkg::*;

    adc_packet_u                        pkt_q;     // Packet being filled
    adc_packet_u                        pkt_nxt;
    logic [$clog2(SLOTS_PER_PKT)-1:0]   slot_cnt;  // Next free slot
    logic                               full;

    //////////////////////////////
    // Slot fill
    //////////////////////////////

    always_comb
    begin
        pkt_nxt = pkt_q;
        if (sample.valid)
        begin
            pkt_nxt.fields.hdr            = HDR_W'(sample.vmm);  // Zero-extended chip index
            pkt_nxt.fields.slot[slot_cnt] = sample.data;
        end
    end

    assign full = sample.valid && (slot_cnt == SLOTS_PER_PKT - 1);

    //////////////////////////////
    // Emit and clear
    //////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            pkt_q     <= '0;
            slot_cnt  <= '0;
            pkt.valid <= 1'b0;
            pkt.last  <= 1'b0;
        end
        else
        begin
            // Flush with nothing collected only sends the last marker
            pkt.valid <= full || (flush_req && slot_cnt != '0);
            pkt.last  <= flush_req;

            if (full || flush_req)
            begin
                pkt.packet <= pkt_nxt;
                pkt_q      <= '0;  // Unused slots of a partial packet read zero
                slot_cnt   <= '0;
            end
            else
            begin
                pkt_q <= pkt_nxt;
                if (sample.valid)
                    slot_cnt <= slot_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/conversion_ctrl.sv
`timescale 1ns/10ps

module conversion_ctrl
(
    input  logic                              clk200,
    input  logic                              rst,
    input  logic                              sample_req,
    input  logic [adc_cfg_pkg::VMM_IDX_W-1:0] vmm_sel,
    input  adc_frame_pkg::conv_rsp_t          adc_rsp,
    output adc_frame_pkg::conv_req_t          adc_req,
    output adc_frame_pkg::sample_t            sample,
    output logic                              sample_done
);

    import adc_cfg_pkg::*;
    import adc_frame_pkg::*;

    logic                 pending;  // Waiting for the ADC result
    logic [VMM_IDX_W-1:0] vmm_q;    // Chip of the conversion in flight
    sample_t              smp_q;

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            pending       <= 1'b0;
            adc_req.start <= 1'b0;
            smp_q.valid   <= 1'b0;
        end
        else
        begin
            // Never a second start while one is outstanding
            adc_req.start <= sample_req && !pending;
            smp_q.valid   <= adc_rsp.done;

            if (sample_req)
            begin
                pending      <= 1'b1;
                adc_req.chan <= {{(CHAN_W - VMM_IDX_W){1'b0}}, vmm_sel};  // PDO channel
                vmm_q        <= vmm_sel;
            end
            else if (adc_rsp.done)
                pending <= 1'b0;

            if (adc_rsp.done)
            begin
                smp_q.vmm  <= vmm_q;
                smp_q.data <= adc_rsp.data;
            end
        end
    end

    assign sample      = smp_q;
    assign sample_done = smp_q.valid;  // Same cycle as the tagged result

    // ADC answers only a start it was given
    a_done_has_start: assert property (@(posedge clk200) disable iff (rst)
        adc_rsp.done |-> pending);

endmodule

// File: logic/scan_sequencer.sv
`timescale 1ns/10ps

module scan_sequencer
(
    input  logic                                 clk200,
    input  logic                                 rst,
    input  logic                                 data_in_rdy,
    input  logic [adc_cfg_pkg::VMM_ID_W-1:0]     vmm_id,
    input  logic [adc_cfg_pkg::SAMPLE_CNT_W-1:0] sample_size,
    input  logic [adc_cfg_pkg::DELAY_W-1:0]      delay_in,
    input  logic                                 udp_done,
    input  logic                                 sample_done,
    input  logic                                 frame_done,
    output logic                                 sample_req,
    output logic                                 flush_req,
    output logic [adc_cfg_pkg::VMM_IDX_W-1:0]    vmm_sel,
    output logic                                 busy
);

    import adc_cfg_pkg::*;

    enum logic [2:0] {S_IDLE, S_ARM, S_CONV, S_GAP, S_FLUSH, S_RELEASE} state;

    logic                    req_all;   // Id outside 1..8
    logic                    scan_all;
    logic [SAMPLE_CNT_W-1:0] size_q;
    logic [DELAY_W-1:0]      delay_q;
    logic [SAMPLE_CNT_W-1:0] smp_cnt;   // Requests issued for this chip
    logic [DELAY_W-1:0]      gap_cnt;

    assign req_all = (vmm_id == '0) || (vmm_id > VMM_ID_W'(NUM_VMM));

    //////////////////////////////
    // Run state machine
    //////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state      <= S_IDLE;
            busy       <= 1'b0;
            sample_req <= 1'b0;
            flush_req  <= 1'b0;
            smp_cnt    <= '0;
            gap_cnt    <= '0;
        end
        else
        begin
            sample_req <= 1'b0;
            flush_req  <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (data_in_rdy)
                    begin
                        busy  <= 1'b1;
                        state <= S_ARM;
                    end
                end

                S_ARM: // First conversion of a chip
                begin
                    sample_req <= 1'b1;
                    smp_cnt    <= smp_cnt + 1'b1;
                    state      <= S_CONV;
                end

                S_CONV:
                begin
                    if (sample_done)
                    begin
                        if (smp_cnt >= size_q)
                        begin
                            flush_req <= 1'b1;  // Push out the partial packet
                            state     <= S_FLUSH;
                        end
                        else
                        begin
                            gap_cnt <= '0;
                            state   <= S_GAP;
                        end
                    end
                end

                // Idle for delay_in+1 cycles before the next request
                S_GAP:
                begin
                    if (gap_cnt == delay_q)
                    begin
                        sample_req <= 1'b1;
                        smp_cnt    <= smp_cnt + 1'b1;
                        state      <= S_CONV;
                    end
                    else
                        gap_cnt <= gap_cnt + 1'b1;
                end

                S_FLUSH:
                begin
                    if (frame_done)
                    begin
                        smp_cnt <= '0;
                        if (scan_all && vmm_sel != VMM_IDX_W'(NUM_VMM - 1))
                            state <= S_ARM;
                        else
                            state <= S_RELEASE;
                    end
                end

                S_RELEASE: // Old command gone and frame sent
                begin
                    if (!data_in_rdy && udp_done)
                    begin
                        busy  <= 1'b0;
                        state <= S_IDLE;
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    // Request latch and chip stepping
    always_ff @(posedge clk200)
    begin
        if (state == S_IDLE && data_in_rdy)
        begin
            scan_all <= req_all;
            size_q   <= sample_size;
            delay_q  <= delay_in;
            vmm_sel  <= req_all ? '0 : vmm_id[VMM_IDX_W-1:0] - 1'b1;  // Ids count from 1
        end
        else if (state == S_FLUSH && frame_done && scan_all)
            vmm_sel <= vmm_sel + 1'b1;
    end

    // A finished sample must answer the request in flight
    a_done_in_conv: assert property (@(posedge clk200) disable iff (rst)
        sample_done |-> (state == S_CONV && !sample_req));

endmodule

// File: logic/adc_frame_pkg.sv
package adc_frame_pkg;

    import adc_cfg_pkg::*;

    // Conversion start toward the ADC
    typedef struct packed {
        logic              start;
        logic [CHAN_W-1:0] chan;
    } conv_req_t;

    // Result coming back with a single-cycle done strobe
    typedef struct packed {
        logic                done;
        logic [SAMPLE_W-1:0] data;
    } conv_rsp_t;

    // Result tagged with the chip it belongs to
    typedef struct packed {
        logic                 valid;
        logic [VMM_IDX_W-1:0] vmm;
        logic [SAMPLE_W-1:0]  data;
    } sample_t;

    //////////////////////////////
    // 64-bit packet filled by slot and sent by word
    //////////////////////////////

    typedef union packed {
        struct packed {
            logic [HDR_W-1:0]                       hdr;   // Chip index
            logic [SLOTS_PER_PKT-1:0][SAMPLE_W-1:0] slot;  // Slot k at bit 12k
        } fields;
        struct packed {
            logic [FIFO_W-1:0] upper;  // Written first
            logic [FIFO_W-1:0] lower;
        } words;
    } adc_packet_u;

    // Last without valid marks an empty flush
    typedef struct packed {
        logic        valid;
        logic        last;
        adc_packet_u packet;
    } pkt_t;

endpackage

// File: logic/adc_cfg_pkg.sv
package adc_cfg_pkg;

    //////////////////////////////
    // ADC and chip selection
    //////////////////////////////

    localparam int SAMPLE_W  = 12;  // ADC result
    localparam int VMM_IDX_W = 3;   // Chip index 0..7
    localparam int CHAN_W    = 5;   // ADC channel field
    localparam int NUM_VMM   = 8;
    localparam int VMM_ID_W  = 16;  // External id where 1..8 picks one chip

    //////////////////////////////
    // Packet layout
    //////////////////////////////

    localparam int SLOTS_PER_PKT = 5;
    localparam int PKT_W         = 64;

    // Whatever the five slots leave over holds the chip index
    localparam int HDR_W  = PKT_W - SLOTS_PER_PKT * SAMPLE_W;
    localparam int FIFO_W = PKT_W / 2;  // Two FIFO words per packet

    //////////////////////////////
    // Frame and run limits
    //////////////////////////////

    localparam int MAX_PACKETS  = 150;  // Packets per UDP frame
    localparam int PKT_CNT_W    = 9;
    localparam int PKT_LEN_W    = 12;
    localparam int SAMPLE_CNT_W = 11;
    localparam int DELAY_W      = 18;   // Idle gap between conversions

endpackage
